/* bench/ctrlUnitStimulus.txt */
// op fn ov eq gt dz delay  len memwaits regw dst memw epcw vector pcsrc alu
// len leaves out the memory waits, which add memwaits times MemWaitCycles
00 20 0 0 0 0 0  9 0 1 1 0 0 0 1 1
00 22 0 0 0 0 0  9 0 1 1 0 0 0 1 2
00 2a 0 0 0 0 0  7 0 1 1 0 0 0 1 7
08 00 0 0 0 0 0  9 0 1 0 0 0 0 1 1
09 00 1 0 0 0 0  9 0 1 0 0 0 0 1 1
0a 00 0 0 0 0 0  7 0 1 0 0 0 0 1 7
04 00 0 1 0 0 0  9 0 0 0 0 0 0 2 7
04 00 0 0 0 0 0  8 0 0 0 0 0 0 1 7
05 00 0 0 0 0 0  9 0 0 0 0 0 0 2 7
07 00 0 0 1 0 0  9 0 0 0 0 0 0 2 7
06 00 0 0 1 0 0  8 0 0 0 0 0 0 1 7
06 00 0 1 0 0 0  9 0 0 0 0 0 0 2 7
02 00 0 0 0 0 0  7 0 0 0 0 0 0 3 0
00 08 0 0 0 0 0  7 0 0 0 0 0 0 1 0
23 00 0 0 0 0 0  9 1 1 0 0 0 0 1 1
2b 00 0 0 0 0 0  9 1 0 0 1 0 0 1 1
00 18 0 0 0 0 1  9 0 0 0 0 0 0 1 0
00 18 0 0 0 0 5  d 0 0 0 0 0 0 1 0
00 1a 0 0 0 0 3  b 0 0 0 0 0 0 1 0
00 20 1 0 0 0 0  b 1 0 0 0 1 4 0 1
08 00 1 0 0 0 0  b 1 0 0 0 1 4 0 1
00 1a 0 0 0 1 0  b 1 0 0 0 1 5 0 0
3f 00 0 0 0 0 0  a 1 0 0 0 1 3 0 0
00 3f 0 0 0 0 0  a 1 0 0 0 1 3 0 0

/* bench/ctrlUnitTb.sv */
`timescale 1ns/10ps

module ctrlUnitTb;

    localparam int MemWaitCycles = 2;
    localparam int FieldCount = 16;     // hex words per stimulus line
    localparam int MaxLines = 64;

    logic clk;
    logic reset;
    ctrlPkg::opcodeT opcode;
    ctrlPkg::functT funct;
    logic overflow, equal, greater;
    logic multDone, divDone, divZero;
    logic memWrite, pcWrite, irWrite, regWrite, abWrite;
    logic aluOutWrite, hiloWrite, epcWrite, multStart, divStart;
    ctrlPkg::aluCtrlT aluControl;
    ctrlPkg::aluSrcAT aluSrcA;
    ctrlPkg::aluSrcBT aluSrcB;
    ctrlPkg::regDstT regDst;
    ctrlPkg::memToRegT memToReg;
    ctrlPkg::pcSourceT pcSource;
    ctrlPkg::iordT iord;
    logic hiloSelect;

    logic [7:0] stim [0:MaxLines*FieldCount-1];
    int lineCount;
    int maxDelay;
    int curLine;

    ctrlUnit #(.MemWaitCycles(MemWaitCycles)) u_ctrlUnit (.*);

    always #5 clk = ~clk;

    function automatic int stimField(input int line, input int idx);
        return int'(stim[line*FieldCount + idx]);
    endfunction

    task automatic abortRun();
        $display("TB FAILED");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic reportMismatch(input string what, input int got, input int exp);
        $display("Mismatch at %0t ns: instruction %0d, %s is %0d, expected %0d",
                 $time, curLine, what, got, exp);
        abortRun();
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        if (got != exp) reportMismatch(what, got, exp);
    endtask

    task automatic checkAlu(input string what, input ctrlPkg::aluCtrlT got,
                            input ctrlPkg::aluCtrlT exp);
        if (got !== exp) reportMismatch(what, int'(got), int'(exp));
    endtask

    task automatic checkPc(input string what, input ctrlPkg::pcSourceT got,
                           input ctrlPkg::pcSourceT exp);
        if (got !== exp) reportMismatch(what, int'(got), int'(exp));
    endtask

    task automatic checkIord(input string what, input ctrlPkg::iordT got,
                             input ctrlPkg::iordT exp);
        if (got !== exp) reportMismatch(what, int'(got), int'(exp));
    endtask

    task automatic checkDst(input string what, input ctrlPkg::regDstT got,
                            input ctrlPkg::regDstT exp);
        if (got !== exp) reportMismatch(what, int'(got), int'(exp));
    endtask

    task automatic checkSrcA(input string what, input ctrlPkg::aluSrcAT got,
                             input ctrlPkg::aluSrcAT exp);
        if (got !== exp) reportMismatch(what, int'(got), int'(exp));
    endtask

    task automatic checkSrcB(input string what, input ctrlPkg::aluSrcBT got,
                             input ctrlPkg::aluSrcBT exp);
        if (got !== exp) reportMismatch(what, int'(got), int'(exp));
    endtask

    task automatic checkMemToReg(input string what, input ctrlPkg::memToRegT got,
                                 input ctrlPkg::memToRegT exp);
        if (got !== exp) reportMismatch(what, int'(got), int'(exp));
    endtask

    task automatic checkHilo(input string what, input logic got, input logic exp);
        if (got !== exp) reportMismatch(what, int'(got), int'(exp));
    endtask

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("Timeout: no end of test after %0d clock cycles", cycles);
        abortRun();
    endtask

    // called on a rising edge
    task automatic applyInputs(input int line);
        opcode <= ctrlPkg::opcodeT'(stimField(line, 0));
        funct <= ctrlPkg::functT'(stimField(line, 1));
        overflow <= (stimField(line, 2) != 0);
        equal <= (stimField(line, 3) != 0);
        greater <= (stimField(line, 4) != 0);
        divZero <= (stimField(line, 5) != 0);
        multDone <= 1'b0;
        divDone <= 1'b0;
    endtask

    task automatic waitFirstFetch();
        int cycles;
        int stray;
        cycles = 0;
        stray = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (memWrite || regWrite || abWrite || aluOutWrite || hiloWrite || epcWrite)
                stray++;
            if (cycles == 2) begin
                checkCount("pcWrite in fetch", int'(pcWrite), 1);
                checkPc("pcSource in fetch", pcSource, ctrlPkg::pcFromAlu);
                checkSrcA("aluSrcA in fetch", aluSrcA, ctrlPkg::srcAPc);
                checkSrcB("aluSrcB in fetch", aluSrcB, ctrlPkg::srcBFour);
            end
        end while (!irWrite && cycles < 8);
        checkCount("cycles from reset to irWrite", cycles, 3);
        checkCount("write enables before fetch", stray, 0);
    endtask

    // window runs from this irWrite pulse to the next one
    task automatic runInstr(input int line);
        int p;
        int delay;
        int strobeCycle;
        int regWrites;
        int memWrites;
        int epcWrites;
        int hiloWrites;
        int expLen;
        int expHilo;
        logic strobeDiv;
        logic ended;
        logic pendingPc;
        logic hiloSeen;
        logic expHiloSel;
        ctrlPkg::pcSourceT pendingSrc;
        ctrlPkg::pcSourceT finalSrc;
        ctrlPkg::aluSrcAT pendingSrcA;
        ctrlPkg::aluSrcBT pendingSrcB;
        ctrlPkg::aluSrcBT srcBSeen;
        ctrlPkg::aluSrcBT expSrcB;
        ctrlPkg::memToRegT wbSeen;
        ctrlPkg::memToRegT expWb;
        ctrlPkg::regDstT dstSeen;
        ctrlPkg::iordT vecSeen;
        ctrlPkg::aluCtrlT aluSeen;

        curLine = line;
        delay = stimField(line, 6);
        p = 0;
        strobeCycle = -1;
        regWrites = 0;
        memWrites = 0;
        epcWrites = 0;
        hiloWrites = 0;
        strobeDiv = 1'b0;
        ended = 1'b0;
        pendingPc = 1'b0;
        hiloSeen = 1'b0;
        pendingSrc = ctrlPkg::pcFromAlu;
        finalSrc = ctrlPkg::pcFromAlu;  // pc + 4 from fetch
        pendingSrcA = '0;
        pendingSrcB = '0;
        srcBSeen = '0;
        wbSeen = '0;
        dstSeen = '0;
        vecSeen = '0;
        aluSeen = '0;
        while (!ended) begin
            @(posedge clk);
            if (p == 0) applyInputs(line);
            if (strobeCycle >= 0 && delay > 0 && p + 1 == strobeCycle + delay) begin
                if (strobeDiv) divDone <= 1'b1;
                else multDone <= 1'b1;
            end
            @(negedge clk);
            p++;
            if (irWrite) begin
                ended = 1'b1;   // fetchIr of the next instruction
            end else begin
                // a pcWrite just before irWrite is the next fetch
                if (pendingPc) finalSrc = pendingSrc;
                pendingPc = pcWrite;
                pendingSrc = pcSource;
                pendingSrcA = aluSrcA;
                pendingSrcB = aluSrcB;
                if (p == 3) begin
                    aluSeen = aluControl;   // execute
                    srcBSeen = aluSrcB;
                end
                if (multStart || divStart) begin
                    strobeCycle = p;
                    strobeDiv = divStart;
                end
                if (regWrite) begin
                    regWrites++;
                    dstSeen = regDst;
                    wbSeen = memToReg;
                end
                if (memWrite) memWrites++;
                if (epcWrite) epcWrites++;
                if (hiloWrite) begin
                    hiloWrites++;
                    hiloSeen = hiloSelect;
                end
                if (pcWrite && pcSource == ctrlPkg::pcFromMem) vecSeen = iord;
            end
        end

        // immediate formats feed the sign-extended field to ALU input B
        case (opcode)
            ctrlPkg::opAddi, ctrlPkg::opAddiu, ctrlPkg::opSlti,
            ctrlPkg::opLw, ctrlPkg::opSw: expSrcB = ctrlPkg::srcBImm;
            default: expSrcB = ctrlPkg::srcBRegB;
        endcase
        if (opcode == ctrlPkg::opLw)
            expWb = ctrlPkg::memToRegMem;
        else if (opcode == ctrlPkg::opSlti
                 || (opcode == ctrlPkg::opRType && funct == ctrlPkg::fnSlt))
            expWb = ctrlPkg::memToRegLess;
        else
            expWb = ctrlPkg::memToRegAluOut;
        if (funct == ctrlPkg::fnDiv) expHiloSel = ctrlPkg::hiloFromDiv;
        else expHiloSel = ctrlPkg::hiloFromMult;

        expLen = stimField(line, 7) + stimField(line, 8) * MemWaitCycles;
        expHilo = (delay > 0 && stimField(line, 5) == 0) ? 1 : 0;
        checkCount("length", p, expLen);
        checkCount("regWrite count", regWrites, stimField(line, 9));
        if (regWrites > 0) begin
            checkDst("regDst", dstSeen, ctrlPkg::regDstT'(stimField(line, 10)));
            checkMemToReg("memToReg", wbSeen, expWb);
        end
        checkCount("memWrite count", memWrites, stimField(line, 11));
        checkCount("epcWrite count", epcWrites, stimField(line, 12));
        if (epcWrites > 0)
            checkIord("exception vector", vecSeen, ctrlPkg::iordT'(stimField(line, 13)));
        checkCount("hiloWrite count", hiloWrites, expHilo);
        if (hiloWrites > 0) checkHilo("hiloSelect", hiloSeen, expHiloSel);
        checkPc("final pcSource", finalSrc, ctrlPkg::pcSourceT'(stimField(line, 14)));
        checkAlu("aluControl in execute", aluSeen, ctrlPkg::aluCtrlT'(stimField(line, 15)));
        checkSrcB("aluSrcB in execute", srcBSeen, expSrcB);
        checkCount("pcWrite in fetch", int'(pendingPc), 1);
        checkPc("pcSource in fetch", pendingSrc, ctrlPkg::pcFromAlu);
        checkSrcA("aluSrcA in fetch", pendingSrcA, ctrlPkg::srcAPc);
        checkSrcB("aluSrcB in fetch", pendingSrcB, ctrlPkg::srcBFour);
    endtask

    initial begin
        int budget;
        clk = 1'b0;
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        overflow = 1'b0;
        equal = 1'b0;
        greater = 1'b0;
        multDone = 1'b0;
        divDone = 1'b0;
        divZero = 1'b0;
        curLine = 0;

        for (int i = 0; i < MaxLines*FieldCount; i++) stim[i] = 8'hff;  // end marker
        $readmemh("bench/ctrlUnitStimulus.txt", stim);
        lineCount = 0;
        maxDelay = 0;
        for (int i = 0; i < MaxLines; i++) begin
            if (stim[i*FieldCount] != 8'hff && lineCount == i) lineCount = i + 1;
        end
        for (int i = 0; i < lineCount; i++) begin
            if (stimField(i, 6) > maxDelay) maxDelay = stimField(i, 6);
        end
        if (lineCount == 0) begin
            $display("The stimulus file holds no instructions");
            abortRun();
        end

        budget = 10 + lineCount * (20 + MemWaitCycles + maxDelay);
        fork
            watchdog(budget);
        join_none

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        waitFirstFetch();
        for (int i = 0; i < lineCount; i++) runInstr(i);

        if (u_ctrlUnit.u_ctrlUnitChecker.failCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Assertion failures in the output checker: %0d",
                     u_ctrlUnit.u_ctrlUnitChecker.failCount);
            abortRun();
        end
    end

endmodule

/* bench/ctrlUnit_checker.sv */
`timescale 1ns/10ps

module ctrlUnit_checker (
    input logic clk,
    input logic reset,
    input logic memWrite,
    input logic pcWrite,
    input logic irWrite,
    input logic regWrite,
    input logic abWrite,
    input logic aluOutWrite,
    input logic hiloWrite,
    input logic epcWrite,
    input logic multStart,
    input logic divStart
);

    logic anyEnable;
    int failCount = 0;  // assertion failures so far

    assign anyEnable = memWrite || pcWrite || irWrite || regWrite || abWrite
                       || aluOutWrite || hiloWrite || epcWrite || multStart || divStart;

    // fetchAddr drives nothing
    quietAfterReset: assert property (@(posedge clk) reset |=> !anyEnable)
        else begin
            $error("write enable or start strobe high right after reset");
            failCount++;
        end

    singleMultStrobe: assert property (@(posedge clk) disable iff (reset)
        multStart |=> !multStart)
        else begin
            $error("multStart high for two cycles in a row");
            failCount++;
        end

    noMemAndRegWrite: assert property (@(posedge clk) disable iff (reset)
        !(memWrite && regWrite))
        else begin
            $error("memWrite and regWrite high in the same cycle");
            failCount++;
        end

endmodule

bind ctrlUnit ctrlUnit_checker u_ctrlUnitChecker (.*);

/* hw/ctrlEncoder.sv */
`timescale 1ns/10ps

module ctrlEncoder (
    input logic clk,
    input ctrlPkg::ctrlStateT state,
    decodeIf.enc dec,
    output logic memWrite,
    output logic pcWrite,
    output logic irWrite,
    output logic regWrite,
    output logic abWrite,
    output logic aluOutWrite,
    output logic hiloWrite,
    output logic epcWrite,
    output logic multStart,
    output logic divStart,
    output ctrlPkg::aluCtrlT aluControl,
    output ctrlPkg::aluSrcAT aluSrcA,
    output ctrlPkg::aluSrcBT aluSrcB,
    output ctrlPkg::regDstT regDst,
    output ctrlPkg::memToRegT memToReg,
    output ctrlPkg::pcSourceT pcSource,
    output ctrlPkg::iordT iord,
    output logic hiloSelect
);

    ctrlPkg::ctrlStateT lastState;
    ctrlPkg::iordT excCause;
    ctrlPkg::aluSrcBT regSrcB;
    ctrlPkg::regDstT destSel;

    assign regSrcB = dec.writeRt ? ctrlPkg::srcBImm : ctrlPkg::srcBRegB;
    assign destSel = dec.writeRt ? ctrlPkg::regDstRt : ctrlPkg::regDstRd;

    always_ff @(posedge clk) begin
        lastState <= state;
    end

    // vector picked by the state that trapped
    always_ff @(posedge clk) begin
        if (state == ctrlPkg::excEpc) begin
            case (lastState)
                ctrlPkg::aluResult: excCause <= ctrlPkg::iordVecOverflow;
                ctrlPkg::divWait: excCause <= ctrlPkg::iordVecDivZero;
                default: excCause <= ctrlPkg::iordVecOpcode;
            endcase
        end
    end

    always_comb begin
        {memWrite, pcWrite, irWrite, regWrite, abWrite} = '0;
        {aluOutWrite, hiloWrite, epcWrite, multStart, divStart} = '0;
        aluControl = ctrlPkg::aluAdd;   // PC + 4 unless told otherwise
        aluSrcA = ctrlPkg::srcAPc;
        aluSrcB = ctrlPkg::srcBFour;
        regDst = ctrlPkg::regDstRt;
        memToReg = ctrlPkg::memToRegAluOut;
        pcSource = ctrlPkg::pcFromAlu;
        iord = ctrlPkg::iordPc;
        hiloSelect = (dec.instrClass == ctrlPkg::div) ? ctrlPkg::hiloFromDiv
                                                      : ctrlPkg::hiloFromMult;
        case (state)
            ctrlPkg::fetchPc: pcWrite = 1'b1;
            ctrlPkg::fetchIr: irWrite = 1'b1;
            ctrlPkg::decodeTarget: begin
                aluSrcB = ctrlPkg::srcBBranch; // branch target into ALUOut
                aluOutWrite = 1'b1;
            end
            ctrlPkg::decodeRegs: abWrite = 1'b1;
            ctrlPkg::execute: begin
                aluControl = dec.aluOp;
                aluSrcA = ctrlPkg::srcARegA;
                aluSrcB = ctrlPkg::srcBRegB;
                case (dec.instrClass)
                    ctrlPkg::aluReg, ctrlPkg::aluImm: begin
                        aluSrcB = regSrcB;
                        aluOutWrite = 1'b1;
                    end
                    ctrlPkg::load, ctrlPkg::store: begin
                        aluSrcB = ctrlPkg::srcBImm;
                        aluOutWrite = 1'b1;
                    end
                    ctrlPkg::setLess: begin
                        aluSrcB = regSrcB;
                        regWrite = 1'b1;
                        regDst = destSel;
                        memToReg = ctrlPkg::memToRegLess;
                    end
                    ctrlPkg::jumpReg: pcWrite = 1'b1;
                    ctrlPkg::jump: begin
                        pcWrite = 1'b1;
                        pcSource = ctrlPkg::pcFromJump;
                    end
                    ctrlPkg::mult: multStart = 1'b1;
                    ctrlPkg::div: divStart = 1'b1;
                    default: ;
                endcase
            end
            ctrlPkg::aluResult: begin
                aluControl = dec.aluOp; // hold inputs so overflow stays valid
                aluSrcA = ctrlPkg::srcARegA;
                aluSrcB = regSrcB;
            end
            ctrlPkg::regWriteback: begin
                regWrite = 1'b1;
                regDst = destSel;
            end
            ctrlPkg::branchCompare: begin
                aluControl = dec.aluOp;
                aluSrcA = ctrlPkg::srcARegA;
                aluSrcB = ctrlPkg::srcBRegB;
            end
            ctrlPkg::branchTake: begin
                pcWrite = 1'b1;
                pcSource = ctrlPkg::pcFromBranch;
            end
            ctrlPkg::memAddr: begin
                iord = ctrlPkg::iordAlu;
                aluSrcA = ctrlPkg::srcARegA;
                aluSrcB = ctrlPkg::srcBImm;
            end
            ctrlPkg::memWait: begin
                if (dec.instrClass == ctrlPkg::load || dec.instrClass == ctrlPkg::store)
                    iord = ctrlPkg::iordAluOut;
                else
                    iord = excCause;
            end
            ctrlPkg::loadWriteback: begin
                iord = ctrlPkg::iordAluOut;
                regWrite = 1'b1;
                regDst = destSel;
                memToReg = ctrlPkg::memToRegMem;
            end
            ctrlPkg::storeWrite: begin
                iord = ctrlPkg::iordAluOut;
                memWrite = 1'b1;
            end
            ctrlPkg::hiloWrite: hiloWrite = 1'b1;
            ctrlPkg::excEpc: begin
                aluControl = ctrlPkg::aluSub; // PC - 4 back to the faulting instr
                epcWrite = 1'b1;
            end
            ctrlPkg::excVector: iord = excCause;
            ctrlPkg::excJump: begin
                iord = excCause;
                pcWrite = 1'b1;
                pcSource = ctrlPkg::pcFromMem;
            end
            default: ;
        endcase
    end

endmodule

/* hw/ctrlPkg.sv */
package ctrlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [2:0] aluCtrlT;
    typedef logic [1:0] aluSrcAT;
    typedef logic [1:0] aluSrcBT;
    typedef logic [2:0] regDstT;
    typedef logic [3:0] memToRegT;
    typedef logic [2:0] pcSourceT;
    typedef logic [2:0] iordT;

    typedef enum logic [3:0] {
        aluReg, aluImm, setLess, jumpReg, jump,
        branchEq, branchNe, branchGt, branchLe,
        load, store, mult, div, illegal
    } instrClassT;

    typedef enum logic [4:0] {
        fetchAddr, fetchPc, fetchIr, decodeTarget, decodeRegs, execute,
        aluResult, regWriteback, branchCompare, branchTake,
        memAddr, memWait, loadWriteback, storeWrite,
        multWait, divWait, hiloWrite, excEpc, excVector, excJump, done
    } ctrlStateT;

    // opcodes
    localparam opcodeT opRType = 6'h00;
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opBle   = 6'h06;
    localparam opcodeT opBgt   = 6'h07;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opSlti  = 6'h0a;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;

    // R-type funct
    localparam functT fnJr   = 6'h08;
    localparam functT fnMult = 6'h18;
    localparam functT fnDiv  = 6'h1a;
    localparam functT fnAdd  = 6'h20;
    localparam functT fnSub  = 6'h22;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnSlt  = 6'h2a;

    localparam aluCtrlT aluPassA   = 3'd0;
    localparam aluCtrlT aluAdd     = 3'd1;
    localparam aluCtrlT aluSub     = 3'd2;
    localparam aluCtrlT aluAnd     = 3'd3;
    localparam aluCtrlT aluCompare = 3'd7;

    localparam aluSrcAT srcAPc   = 2'd0;
    localparam aluSrcAT srcARegA = 2'd1;

    localparam aluSrcBT srcBRegB   = 2'd0;
    localparam aluSrcBT srcBFour   = 2'd1;
    localparam aluSrcBT srcBImm    = 2'd2;
    localparam aluSrcBT srcBBranch = 2'd3; // imm shifted by two

    localparam regDstT regDstRt = 3'd0;
    localparam regDstT regDstRd = 3'd1;

    localparam memToRegT memToRegAluOut = 4'd0;
    localparam memToRegT memToRegMem    = 4'd1;
    localparam memToRegT memToRegLess   = 4'd4;

    localparam pcSourceT pcFromMem    = 3'd0;
    localparam pcSourceT pcFromAlu    = 3'd1;
    localparam pcSourceT pcFromBranch = 3'd2;
    localparam pcSourceT pcFromJump   = 3'd3;

    localparam iordT iordPc          = 3'd0;
    localparam iordT iordAlu         = 3'd1;
    localparam iordT iordAluOut      = 3'd2;
    localparam iordT iordVecOpcode   = 3'd3;
    localparam iordT iordVecOverflow = 3'd4;
    localparam iordT iordVecDivZero  = 3'd5;

    localparam logic hiloFromMult = 1'b0;
    localparam logic hiloFromDiv  = 1'b1;

endpackage

/* hw/ctrlSequencer.sv */
`timescale 1ns/10ps

module ctrlSequencer #(
    parameter int MemWaitCycles = 2
) (
    input logic clk,
    input logic reset,
    decodeIf.seq dec,
    input logic overflow,
    input logic equal,
    input logic greater,
    input logic multDone,
    input logic divDone,
    input logic divZero,
    output ctrlPkg::ctrlStateT state
);

    localparam int WaitW = (MemWaitCycles > 1) ? $clog2(MemWaitCycles) : 1;
    localparam logic [WaitW-1:0] lastWait = WaitW'(MemWaitCycles - 1);

    ctrlPkg::ctrlStateT nextState;
    logic [WaitW-1:0] waitCount;
    logic branchTaken;

    // branch condition from the ALU compare flags
    always_comb begin
        case (dec.instrClass)
            ctrlPkg::branchEq: branchTaken = equal;
            ctrlPkg::branchNe: branchTaken = !equal;
            ctrlPkg::branchGt: branchTaken = greater;
            ctrlPkg::branchLe: branchTaken = !greater;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            ctrlPkg::fetchAddr: nextState = ctrlPkg::fetchPc;
            ctrlPkg::fetchPc: nextState = ctrlPkg::fetchIr;
            ctrlPkg::fetchIr: nextState = ctrlPkg::decodeTarget;
            ctrlPkg::decodeTarget: nextState = ctrlPkg::decodeRegs;
            ctrlPkg::decodeRegs: nextState = ctrlPkg::execute;
            ctrlPkg::execute: begin
                case (dec.instrClass)
                    ctrlPkg::aluReg, ctrlPkg::aluImm: nextState = ctrlPkg::aluResult;
                    ctrlPkg::setLess, ctrlPkg::jumpReg,
                    ctrlPkg::jump: nextState = ctrlPkg::done;
                    ctrlPkg::branchEq, ctrlPkg::branchNe, ctrlPkg::branchGt,
                    ctrlPkg::branchLe: nextState = ctrlPkg::branchCompare;
                    ctrlPkg::load, ctrlPkg::store: nextState = ctrlPkg::memAddr;
                    ctrlPkg::mult: nextState = ctrlPkg::multWait;
                    ctrlPkg::div: nextState = ctrlPkg::divWait;
                    default: nextState = ctrlPkg::excEpc; // unknown opcode
                endcase
            end
            ctrlPkg::aluResult: begin
                if (dec.trapOverflow && overflow) nextState = ctrlPkg::excEpc;
                else nextState = ctrlPkg::regWriteback;
            end
            ctrlPkg::regWriteback: nextState = ctrlPkg::done;
            ctrlPkg::branchCompare: begin
                nextState = branchTaken ? ctrlPkg::branchTake : ctrlPkg::done;
            end
            ctrlPkg::branchTake: nextState = ctrlPkg::done;
            ctrlPkg::memAddr: nextState = ctrlPkg::memWait;
            ctrlPkg::memWait: begin
                // shared by load, store and the exception vector fetch
                if (waitCount == lastWait) begin
                    case (dec.instrClass)
                        ctrlPkg::load: nextState = ctrlPkg::loadWriteback;
                        ctrlPkg::store: nextState = ctrlPkg::storeWrite;
                        default: nextState = ctrlPkg::excJump;
                    endcase
                end
            end
            ctrlPkg::loadWriteback: nextState = ctrlPkg::done;
            ctrlPkg::storeWrite: nextState = ctrlPkg::done;
            ctrlPkg::multWait: if (multDone) nextState = ctrlPkg::hiloWrite;
            ctrlPkg::divWait: begin
                if (divZero) nextState = ctrlPkg::excEpc;
                else if (divDone) nextState = ctrlPkg::hiloWrite;
            end
            ctrlPkg::hiloWrite: nextState = ctrlPkg::done;
            ctrlPkg::excEpc: nextState = ctrlPkg::excVector;
            ctrlPkg::excVector: nextState = ctrlPkg::memWait;
            ctrlPkg::excJump: nextState = ctrlPkg::done;
            default: nextState = ctrlPkg::fetchAddr; // done and stray codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrlPkg::fetchAddr;
            waitCount <= '0;
        end else begin
            state <= nextState;
            if (state == ctrlPkg::memWait) waitCount <= waitCount + 1'b1;
            else waitCount <= '0;
        end
    end

endmodule

/* hw/ctrlUnit.sv */
`timescale 1ns/10ps

module ctrlUnit #(
    parameter int MemWaitCycles = 2
) (
    input logic clk,
    input logic reset,
    input ctrlPkg::opcodeT opcode,
    input ctrlPkg::functT funct,
    input logic overflow,
    input logic equal,
    input logic greater,
    input logic multDone,
    input logic divDone,
    input logic divZero,
    output logic memWrite,
    output logic pcWrite,
    output logic irWrite,
    output logic regWrite,
    output logic abWrite,
    output logic aluOutWrite,
    output logic hiloWrite,
    output logic epcWrite,
    output logic multStart,
    output logic divStart,
    output ctrlPkg::aluCtrlT aluControl,
    output ctrlPkg::aluSrcAT aluSrcA,
    output ctrlPkg::aluSrcBT aluSrcB,
    output ctrlPkg::regDstT regDst,
    output ctrlPkg::memToRegT memToReg,
    output ctrlPkg::pcSourceT pcSource,
    output ctrlPkg::iordT iord,
    output logic hiloSelect
);

    ctrlPkg::ctrlStateT state;

    decodeIf decBus ();

    instrDecoder u_instrDecoder (.opcode(opcode), .funct(funct), .dec(decBus.source));

    ctrlSequencer #(.MemWaitCycles(MemWaitCycles)) u_ctrlSequencer (
        .clk(clk), .reset(reset), .dec(decBus.seq),
        .overflow(overflow), .equal(equal), .greater(greater),
        .multDone(multDone), .divDone(divDone), .divZero(divZero),
        .state(state)
    );

    // outputs follow the current state
    ctrlEncoder u_ctrlEncoder (
        .clk(clk), .state(state), .dec(decBus.enc),
        .memWrite(memWrite), .pcWrite(pcWrite), .irWrite(irWrite), .regWrite(regWrite),
        .abWrite(abWrite), .aluOutWrite(aluOutWrite), .hiloWrite(hiloWrite),
        .epcWrite(epcWrite), .multStart(multStart), .divStart(divStart),
        .aluControl(aluControl), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .regDst(regDst),
        .memToReg(memToReg), .pcSource(pcSource), .iord(iord), .hiloSelect(hiloSelect)
    );

endmodule

/* hw/decodeIf.sv */
`timescale 1ns/10ps

interface decodeIf;

    ctrlPkg::instrClassT instrClass;
    ctrlPkg::aluCtrlT aluOp;
    logic writeRt;      // destination is rt
    logic trapOverflow;

    modport source (output instrClass, aluOp, writeRt, trapOverflow);

    modport seq (input instrClass, trapOverflow);

    // class needed for strobes and single-cycle writes in execute
    modport enc (input instrClass, aluOp, writeRt);

endinterface

/* hw/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
    input ctrlPkg::opcodeT opcode,
    input ctrlPkg::functT funct,
    decodeIf.source dec
);

    always_comb begin
        dec.instrClass = ctrlPkg::illegal;
        dec.aluOp = ctrlPkg::aluPassA;
        dec.writeRt = 1'b0;
        dec.trapOverflow = 1'b0;
        case (opcode)
            ctrlPkg::opRType: begin
                case (funct)
                    ctrlPkg::fnAdd: begin
                        dec.instrClass = ctrlPkg::aluReg;
                        dec.aluOp = ctrlPkg::aluAdd;
                        dec.trapOverflow = 1'b1;
                    end
                    ctrlPkg::fnSub: begin
                        dec.instrClass = ctrlPkg::aluReg;
                        dec.aluOp = ctrlPkg::aluSub;
                        dec.trapOverflow = 1'b1;
                    end
                    ctrlPkg::fnAnd: begin
                        dec.instrClass = ctrlPkg::aluReg;
                        dec.aluOp = ctrlPkg::aluAnd;
                    end
                    ctrlPkg::fnSlt: begin
                        dec.instrClass = ctrlPkg::setLess;
                        dec.aluOp = ctrlPkg::aluCompare;
                    end
                    ctrlPkg::fnJr: dec.instrClass = ctrlPkg::jumpReg; // pass A to pc
                    ctrlPkg::fnMult: dec.instrClass = ctrlPkg::mult;
                    ctrlPkg::fnDiv: dec.instrClass = ctrlPkg::div;
                    default: dec.instrClass = ctrlPkg::illegal;
                endcase
            end
            ctrlPkg::opAddi, ctrlPkg::opAddiu: begin
                dec.instrClass = ctrlPkg::aluImm;
                dec.aluOp = ctrlPkg::aluAdd;
                dec.writeRt = 1'b1;
                dec.trapOverflow = (opcode == ctrlPkg::opAddi); // addiu never traps
            end
            ctrlPkg::opSlti: begin
                dec.instrClass = ctrlPkg::setLess;
                dec.aluOp = ctrlPkg::aluCompare;
                dec.writeRt = 1'b1;
            end
            ctrlPkg::opBeq: begin
                dec.instrClass = ctrlPkg::branchEq;
                dec.aluOp = ctrlPkg::aluCompare;
            end
            ctrlPkg::opBne: begin
                dec.instrClass = ctrlPkg::branchNe;
                dec.aluOp = ctrlPkg::aluCompare;
            end
            ctrlPkg::opBgt: begin
                dec.instrClass = ctrlPkg::branchGt;
                dec.aluOp = ctrlPkg::aluCompare;
            end
            ctrlPkg::opBle: begin
                dec.instrClass = ctrlPkg::branchLe;
                dec.aluOp = ctrlPkg::aluCompare;
            end
            ctrlPkg::opLw: begin
                dec.instrClass = ctrlPkg::load;
                dec.aluOp = ctrlPkg::aluAdd;
                dec.writeRt = 1'b1;
            end
            ctrlPkg::opSw: begin
                dec.instrClass = ctrlPkg::store;
                dec.aluOp = ctrlPkg::aluAdd;
            end
            ctrlPkg::opJ: dec.instrClass = ctrlPkg::jump;
            default: dec.instrClass = ctrlPkg::illegal;
        endcase
    end

endmodule

/* list.f */
hw/ctrlPkg.sv
hw/decodeIf.sv
hw/instrDecoder.sv
hw/ctrlSequencer.sv
hw/ctrlEncoder.sv
hw/ctrlUnit.sv
bench/ctrlUnit_checker.sv
bench/ctrlUnitTb.sv

/* run.sh */
#!/bin/sh
# build and run the ctrlUnit testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module ctrlUnitTb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VctrlUnitTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1
